// ==== ahb_axi_defs.svh ====
// widths and fixed AXI field values for the AHB-Lite to AXI4 bridge
// included by the package, the RTL and the testbench
`ifndef AHB_AXI_DEFS_SVH
`define AHB_AXI_DEFS_SVH

// ******************************
// data path
// ******************************
`define AHB_ADDR_W      32
`define AHB_DATA_W      32
`define AHB_STRB_W      4

// ******************************
// AXI constants
// ******************************
`define AXI_ID_W        1
`define AXI_LEN_SINGLE  8'd0     // one beat per transaction
`define AXI_BURST_INCR  2'b01

`endif

// ==== ahb_axi_pkg.sv ====
// shared types of the AHB-Lite to AXI4 single-transfer bridge
// compile before the RTL, modules refer to the types by scoped names
`include "ahb_axi_defs.svh"

package ahb_axi_pkg;

   typedef enum logic [1:0] {
      TRANS_IDLE   = 2'b00,
      TRANS_BUSY   = 2'b01,
      TRANS_NONSEQ = 2'b10,
      TRANS_SEQ    = 2'b11
   } htrans_e;

   typedef enum logic [2:0] {
      SIZE_BYTE = 3'b000,
      SIZE_HALF = 3'b001,
      SIZE_WORD = 3'b010
   } hsize_e;

   typedef enum logic [1:0] {
      RESP_OKAY   = 2'b00,
      RESP_EXOKAY = 2'b01,
      RESP_SLVERR = 2'b10,
      RESP_DECERR = 2'b11
   } axi_resp_e;

   // ******************************
   // AHB side
   // ******************************
   typedef struct packed {
      logic                   sel;
      logic                   readyin;
      htrans_e                trans;
      logic                   write;
      hsize_e                 size;
      logic [3:0]             prot;
      logic [`AHB_ADDR_W-1:0] addr;
   } ahb_in_t;

   typedef struct packed {
      logic [`AHB_ADDR_W-1:0] addr;
      hsize_e                 size;
      logic                   write;
      logic [2:0]             prot;        // already in AXI order
      logic [`AHB_STRB_W-1:0] strb;
      logic                   misaligned;
   } ahb_cmd_t;

   // ******************************
   // AXI channels
   // ******************************
   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      logic [`AHB_ADDR_W-1:0] addr;
      logic [7:0]             len;
      logic [2:0]             size;
      logic [1:0]             burst;
      logic [2:0]             prot;
   } axi_ax_t;                             // shared by AW and AR

   typedef struct packed {
      logic [`AHB_DATA_W-1:0] data;
      logic [`AHB_STRB_W-1:0] strb;
      logic                   last;
   } axi_w_t;

   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      axi_resp_e              resp;
   } axi_b_t;

   typedef struct packed {
      logic [`AXI_ID_W-1:0]   id;
      logic [`AHB_DATA_W-1:0] data;
      axi_resp_e              resp;
      logic                   last;
   } axi_r_t;

endpackage

// ==== ahb_cmd_capture.sv ====
// accepts an AHB address phase and registers it as a bridge command
// strobes, the alignment flag and the AXI prot bits are worked out here
`timescale 1ns/1ps
`include "ahb_axi_defs.svh"

module ahb_cmd_capture (
   input  logic                  clk,
   input  logic                  rst_l,
   input  ahb_axi_pkg::ahb_in_t  ahb_in,
   input  logic                  hreadyout,
   output ahb_axi_pkg::ahb_cmd_t cmd,
   output logic                  cmd_vld
);

   logic                   accept;
   logic                   active_trans;
   logic [`AHB_STRB_W-1:0] strb;
   logic                   misaligned;
   ahb_axi_pkg::ahb_cmd_t  cmd_d;

   // NONSEQ and SEQ both start an independent single transfer
   assign active_trans = (ahb_in.trans == ahb_axi_pkg::TRANS_NONSEQ) ||
                         (ahb_in.trans == ahb_axi_pkg::TRANS_SEQ);
   assign accept       = ahb_in.sel & ahb_in.readyin & active_trans & hreadyout;

   always_comb begin
      strb       = '0;
      misaligned = 1'b0;
      case (ahb_in.size)
         ahb_axi_pkg::SIZE_BYTE: strb = 4'b0001 << ahb_in.addr[1:0];
         ahb_axi_pkg::SIZE_HALF: begin
            strb       = 4'b0011 << ahb_in.addr[1:0];
            misaligned = ahb_in.addr[0];
         end
         ahb_axi_pkg::SIZE_WORD: begin
            strb       = 4'b1111;
            misaligned = |ahb_in.addr[1:0];
         end
         default: misaligned = 1'b1;     // wider than the 32-bit path, reject too
      endcase
   end

   always_comb begin
      cmd_d.addr       = ahb_in.addr;
      cmd_d.size       = ahb_in.size;
      cmd_d.write      = ahb_in.write;
      // axi prot is {instruction, non-secure, privileged}
      cmd_d.prot       = {~ahb_in.prot[0], 1'b0, ahb_in.prot[1]};
      cmd_d.strb       = strb;
      cmd_d.misaligned = misaligned;
   end

   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         cmd_vld <= 1'b0;
      end else begin
         cmd_vld <= accept;              // one cycle per accepted phase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cmd <= cmd_d;
      end
   end

endmodule

// ==== ahb_bridge_fsm.sv ====
// AHB data-phase control of the bridge
// stalls with hreadyout low until the AXI side reports done, then
// finishes with OKAY or with the two-cycle ERROR response
`timescale 1ns/1ps
`include "ahb_axi_defs.svh"

module ahb_bridge_fsm (
   input  logic                   clk,
   input  logic                   rst_l,
   input  ahb_axi_pkg::ahb_cmd_t  cmd,
   input  logic                   cmd_vld,
   input  logic                   done,
   input  logic                   done_err,
   input  logic [`AHB_DATA_W-1:0] done_rdata,
   output logic                   issue,
   output logic                   hreadyout,
   output logic                   hresp,
   output logic [`AHB_DATA_W-1:0] hrdata
);

   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      WAIT_AXI = 3'd1,
      ERR1     = 3'd2,
      ERR2     = 3'd3,
      DONE     = 3'd4
   } state_t;

   state_t state;
   state_t state_nxt;

   // ******************************
   // next state
   // ******************************
   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: begin
            if (cmd_vld) begin
               state_nxt = cmd.misaligned ? ERR1 : WAIT_AXI;
            end
         end
         WAIT_AXI: begin
            if (done) begin
               state_nxt = done_err ? ERR1 : DONE;
            end
         end
         ERR1:    state_nxt = ERR2;
         ERR2:    state_nxt = IDLE;
         DONE:    state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         state <= IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // ******************************
   // AHB outputs
   // ******************************
   // a misaligned command never goes out on AXI
   assign issue = (state == IDLE) & cmd_vld & ~cmd.misaligned;

   always_comb begin
      hreadyout = 1'b0;
      hresp     = 1'b0;
      case (state)
         IDLE:    hreadyout = ~cmd_vld;  // first data-phase cycle is a wait state
         ERR1:    hresp     = 1'b1;
         ERR2: begin
            hreadyout = 1'b1;
            hresp     = 1'b1;
         end
         DONE:    hreadyout = 1'b1;
         default: hreadyout = 1'b0;
      endcase
   end

   // read data is held so it is valid in the DONE cycle
   always_ff @(posedge clk) begin
      if (done & ~cmd.write) begin
         hrdata <= done_rdata;
      end
   end

endmodule

// ==== axi_channel_drive.sv ====
// AXI4 master side of the bridge, one single-beat transaction at a time
// an issue pulse raises AW and W or AR; B or R completes the transfer
`timescale 1ns/1ps
`include "ahb_axi_defs.svh"

module axi_channel_drive (
   input  logic                   clk,
   input  logic                   rst_l,
   input  ahb_axi_pkg::ahb_cmd_t  cmd,
   input  logic                   issue,
   input  logic [`AHB_DATA_W-1:0] hwdata,
   output ahb_axi_pkg::axi_ax_t   aw,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output ahb_axi_pkg::axi_w_t    w,
   output logic                   w_valid,
   input  logic                   w_ready,
   input  ahb_axi_pkg::axi_b_t    b,
   input  logic                   b_valid,
   output logic                   b_ready,
   output ahb_axi_pkg::axi_ax_t   ar,
   output logic                   ar_valid,
   input  logic                   ar_ready,
   input  ahb_axi_pkg::axi_r_t    r,
   input  logic                   r_valid,
   output logic                   r_ready,
   output logic                   done,
   output logic                   done_err,
   output logic [`AHB_DATA_W-1:0] done_rdata
);

   logic                   wr_pend;      // write issued, B not taken yet
   logic                   rd_pend;      // read issued, R not taken yet
   logic [`AHB_DATA_W-1:0] wdata_q;
   logic                   b_fire;
   logic                   r_fire;
   logic                   b_err;
   logic                   r_err;

   // ******************************
   // payloads
   // ******************************
   always_comb begin
      aw.id    = '0;
      aw.addr  = cmd.addr;
      aw.len   = `AXI_LEN_SINGLE;
      aw.size  = cmd.size;
      aw.burst = `AXI_BURST_INCR;
      aw.prot  = cmd.prot;
   end

   assign ar = aw;                       // both address channels carry the same fields

   always_comb begin
      w.data = wdata_q;
      w.strb = cmd.strb;
      w.last = 1'b1;                     // single beat
   end

   // hwdata belongs to the data phase that issues the write
   always_ff @(posedge clk) begin
      if (issue & cmd.write) begin
         wdata_q <= hwdata;
      end
   end

   // ******************************
   // handshakes
   // ******************************
   assign b_fire = b_valid & b_ready;
   assign r_fire = r_valid & r_ready;

   always_ff @(posedge clk or posedge rst_l) begin
      if (rst_l) begin
         aw_valid <= 1'b0;
         w_valid  <= 1'b0;
         ar_valid <= 1'b0;
         b_ready  <= 1'b0;
         r_ready  <= 1'b0;
         wr_pend  <= 1'b0;
         rd_pend  <= 1'b0;
      end else begin
         if (issue & cmd.write) begin
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
            wr_pend  <= 1'b1;
         end else begin
            if (aw_valid & aw_ready) aw_valid <= 1'b0;   // AW and W finish on their own
            if (w_valid & w_ready)   w_valid  <= 1'b0;
         end

         if (issue & ~cmd.write) begin
            ar_valid <= 1'b1;
            rd_pend  <= 1'b1;
         end else if (ar_valid & ar_ready) begin
            ar_valid <= 1'b0;
         end

         // B is only taken once both AW and W are through
         if (b_fire) begin
            b_ready <= 1'b0;
            wr_pend <= 1'b0;
         end else if (wr_pend & ~aw_valid & ~w_valid) begin
            b_ready <= 1'b1;
         end

         if (r_fire) begin
            r_ready <= 1'b0;
            rd_pend <= 1'b0;
         end else if (rd_pend & ~ar_valid) begin
            r_ready <= 1'b1;
         end
      end
   end

   // ******************************
   // completion
   // ******************************
   assign b_err = (b.resp == ahb_axi_pkg::RESP_SLVERR) | (b.resp == ahb_axi_pkg::RESP_DECERR);
   assign r_err = (r.resp == ahb_axi_pkg::RESP_SLVERR) | (r.resp == ahb_axi_pkg::RESP_DECERR);

   assign done       = b_fire | r_fire;
   assign done_err   = (b_fire & b_err) | (r_fire & r_err);
   assign done_rdata = r.data;

endmodule

// ==== ahb_to_axi4_top.sv ====
// top level of the AHB-Lite slave to AXI4 master bridge
// single transfers only, one in flight at a time
`timescale 1ns/1ps
`include "ahb_axi_defs.svh"

module ahb_to_axi4_top (
   input  logic                   clk,
   input  logic                   rst_l,
   input  ahb_axi_pkg::ahb_in_t   ahb_in,
   input  logic [`AHB_DATA_W-1:0] hwdata,
   output logic [`AHB_DATA_W-1:0] hrdata,
   output logic                   hreadyout,
   output logic                   hresp,
   output ahb_axi_pkg::axi_ax_t   aw,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output ahb_axi_pkg::axi_w_t    w,
   output logic                   w_valid,
   input  logic                   w_ready,
   input  ahb_axi_pkg::axi_b_t    b,
   input  logic                   b_valid,
   output logic                   b_ready,
   output ahb_axi_pkg::axi_ax_t   ar,
   output logic                   ar_valid,
   input  logic                   ar_ready,
   input  ahb_axi_pkg::axi_r_t    r,
   input  logic                   r_valid,
   output logic                   r_ready
);

   ahb_axi_pkg::ahb_cmd_t  cmd;
   logic                   cmd_vld;
   logic                   issue;
   logic                   done;
   logic                   done_err;
   logic [`AHB_DATA_W-1:0] done_rdata;

   ahb_cmd_capture capture0 (
      .clk       (clk),
      .rst_l     (rst_l),
      .ahb_in    (ahb_in),
      .hreadyout (hreadyout),
      .cmd       (cmd),
      .cmd_vld   (cmd_vld)
   );

   ahb_bridge_fsm fsm0 (
      .clk        (clk),
      .rst_l      (rst_l),
      .cmd        (cmd),
      .cmd_vld    (cmd_vld),
      .done       (done),
      .done_err   (done_err),
      .done_rdata (done_rdata),
      .issue      (issue),
      .hreadyout  (hreadyout),
      .hresp      (hresp),
      .hrdata     (hrdata)
   );

   axi_channel_drive drive0 (
      .clk        (clk),
      .rst_l      (rst_l),
      .cmd        (cmd),
      .issue      (issue),
      .hwdata     (hwdata),
      .aw         (aw),
      .aw_valid   (aw_valid),
      .aw_ready   (aw_ready),
      .w          (w),
      .w_valid    (w_valid),
      .w_ready    (w_ready),
      .b          (b),
      .b_valid    (b_valid),
      .b_ready    (b_ready),
      .ar         (ar),
      .ar_valid   (ar_valid),
      .ar_ready   (ar_ready),
      .r          (r),
      .r_valid    (r_valid),
      .r_ready    (r_ready),
      .done       (done),
      .done_err   (done_err),
      .done_rdata (done_rdata)
   );

endmodule

// ==== ahb_axi_asserts.sv ====
// concurrent checks on the handshakes of the bridge top level
// bound into every instance of the top level
`timescale 1ns/1ps
`include "ahb_axi_defs.svh"

module ahb_axi_asserts (
   input logic                 clk,
   input logic                 rst_l,
   input ahb_axi_pkg::axi_ax_t aw,
   input logic                 aw_valid,
   input logic                 aw_ready,
   input ahb_axi_pkg::axi_w_t  w,
   input logic                 w_valid,
   input logic                 w_ready,
   input ahb_axi_pkg::axi_ax_t ar,
   input logic                 ar_valid,
   input logic                 ar_ready,
   input logic                 hreadyout,
   input logic                 hresp
);

   // ******************************
   // AXI valid stays until ready
   // ******************************
   aw_hold: assert property (@(posedge clk) disable iff (rst_l)
      aw_valid && !aw_ready |=> aw_valid && $stable(aw))
      else $error("aw_valid dropped or aw changed before aw_ready");

   w_hold: assert property (@(posedge clk) disable iff (rst_l)
      w_valid && !w_ready |=> w_valid && $stable(w))
      else $error("w_valid dropped or w changed before w_ready");

   ar_hold: assert property (@(posedge clk) disable iff (rst_l)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar))
      else $error("ar_valid dropped or ar changed before ar_ready");

   // ******************************
   // AHB response
   // ******************************
   err_first: assert property (@(posedge clk) disable iff (rst_l)
      $rose(hresp) |-> !hreadyout)
      else $error("first ERROR cycle has hreadyout high");

   err_second: assert property (@(posedge clk) disable iff (rst_l)
      $rose(hresp) |=> hresp && hreadyout)
      else $error("second ERROR cycle missing");

   ready_after_reset: assert property (@(posedge clk)
      $fell(rst_l) |-> hreadyout && !hresp)
      else $error("bridge not idle after reset");

endmodule

bind ahb_to_axi4_top ahb_axi_asserts asserts0 (
   .clk       (clk),
   .rst_l     (rst_l),
   .aw        (aw),
   .aw_valid  (aw_valid),
   .aw_ready  (aw_ready),
   .w         (w),
   .w_valid   (w_valid),
   .w_ready   (w_ready),
   .ar        (ar),
   .ar_valid  (ar_valid),
   .ar_ready  (ar_ready),
   .hreadyout (hreadyout),
   .hresp     (hresp)
);

// ==== tb_ahb_to_axi4.sv ====
// testbench for the AHB-Lite to AXI4 bridge
// plays one AHB transfer per line of the case file against a 4 KiB AXI slave
// memory with random ready and valid delays
`timescale 1ns/1ps
`include "ahb_axi_defs.svh"

module tb_ahb_to_axi4;

   localparam int CLK_PERIOD      = 100;
   localparam int CYCLES_PER_CASE = 40;
   localparam int MEM_WORDS       = 1024;
   localparam int ERR_ADDR_BIT    = 31;   // slave answers SLVERR here

   typedef struct packed {
      logic                   write;
      logic [2:0]             size;
      logic [`AHB_ADDR_W-1:0] addr;
      logic [`AHB_DATA_W-1:0] wdata;
      logic [`AHB_DATA_W-1:0] rdata;
      logic                   err;
   } case_t;

   logic                   clk    = 1'b0;
   logic                   rst_l  = 1'b1;
   ahb_axi_pkg::ahb_in_t   ahb_in = '0;
   logic [`AHB_DATA_W-1:0] hwdata = '0;
   logic [`AHB_DATA_W-1:0] hrdata;
   logic                   hreadyout;
   logic                   hresp;
   ahb_axi_pkg::axi_ax_t   aw;
   logic                   aw_valid;
   logic                   aw_ready = 1'b0;
   ahb_axi_pkg::axi_w_t    w;
   logic                   w_valid;
   logic                   w_ready  = 1'b0;
   ahb_axi_pkg::axi_b_t    b        = '0;
   logic                   b_valid  = 1'b0;
   logic                   b_ready;
   ahb_axi_pkg::axi_ax_t   ar;
   logic                   ar_valid;
   logic                   ar_ready = 1'b0;
   ahb_axi_pkg::axi_r_t    r        = '0;
   logic                   r_valid  = 1'b0;
   logic                   r_ready;

   integer                 seed = 32'h1fbb;
   logic [`AHB_DATA_W-1:0] mem [MEM_WORDS];
   logic                   aw_seen  = 1'b0;
   logic                   w_seen   = 1'b0;
   logic                   ar_seen  = 1'b0;
   logic [`AHB_ADDR_W-1:0] wr_addr;
   logic [`AHB_ADDR_W-1:0] rd_addr;
   logic [`AHB_DATA_W-1:0] wr_data;
   logic [`AHB_STRB_W-1:0] wr_strb;
   int                     aw_wait;
   int                     w_wait;
   int                     b_wait;
   int                     ar_wait;
   int                     r_wait;
   int                     aw_count = 0;
   int                     ar_count = 0;

   string                  cur_name     = "reset";
   ahb_axi_pkg::axi_ax_t   exp_ax       = '0;
   logic                   axi_expected = 1'b0;
   case_t                  cases[$];
   string                  names[$];
   int                     n_cases      = 0;
   logic                   cases_loaded = 1'b0;

   ahb_to_axi4_top dut0 (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ******************************
   // reporting and compares
   // ******************************
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_rdata(input logic [`AHB_DATA_W-1:0] exp,
                              input logic [`AHB_DATA_W-1:0] act);
      if (act !== exp)
         report_failure($sformatf("Mismatch %s hrdata expected %h actual %h",
                                  cur_name, exp, act));
   endtask

   task automatic check_resp(input logic exp, input logic act);
      if (act !== exp)
         report_failure($sformatf("Mismatch %s hresp expected %b actual %b",
                                  cur_name, exp, act));
   endtask

   task automatic check_ax(input string chan, input ahb_axi_pkg::axi_ax_t exp,
                           input ahb_axi_pkg::axi_ax_t act);
      if (act !== exp)
         report_failure($sformatf("Mismatch %s %s expected %h actual %h",
                                  cur_name, chan, exp, act));
   endtask

   task automatic check_flag(input string sig, input logic exp, input logic act);
      if (act !== exp)
         report_failure($sformatf("Mismatch %s %s expected %b actual %b",
                                  cur_name, sig, exp, act));
   endtask

   function automatic int pick_delay();
      return $unsigned($random(seed)) % 4;   // 0 to 3 cycles
   endfunction

   function automatic logic is_misaligned(input case_t c);
      case (c.size)
         3'd0:    return 1'b0;
         3'd1:    return c.addr[0];
         3'd2:    return |c.addr[1:0];
         default: return 1'b1;
      endcase
   endfunction

   // single beat, INCR
   function automatic ahb_axi_pkg::axi_ax_t expect_ax(input case_t c, input logic [3:0] hprot);
      ahb_axi_pkg::axi_ax_t ax;
      ax.id      = '0;
      ax.addr    = c.addr;
      ax.len     = `AXI_LEN_SINGLE;
      ax.size    = c.size;
      ax.burst   = `AXI_BURST_INCR;
      ax.prot[0] = hprot[1];            // privileged
      ax.prot[1] = 1'b0;                // secure
      ax.prot[2] = !hprot[0];           // instruction when hprot says opcode
      return ax;
   endfunction

   // ******************************
   // AXI slave memory, write side
   // ******************************
   always @(posedge clk) begin : write_slave
      if (rst_l) begin
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         b_valid  <= 1'b0;
         aw_seen  <= 1'b0;
         w_seen   <= 1'b0;
         aw_wait  <= pick_delay();
         w_wait   <= pick_delay();
         b_wait   <= pick_delay();
         for (int i = 0; i < MEM_WORDS; i++)
            mem[i] <= {16'ha5a5, 4'h0, i[9:0], 2'b00};   // fill holds the byte address
      end else begin
         if (aw_valid && aw_ready) begin
            if (!axi_expected)
               report_failure($sformatf("%s: AW transfer for a misaligned case", cur_name));
            check_ax("aw", exp_ax, aw);
            aw_ready <= 1'b0;
            aw_seen  <= 1'b1;
            wr_addr  <= aw.addr;
            aw_count <= aw_count + 1;
            aw_wait  <= pick_delay();
         end else if (aw_valid && !aw_seen) begin
            if (aw_wait == 0) aw_ready <= 1'b1;
            else aw_wait <= aw_wait - 1;
         end
         if (w_valid && w_ready) begin
            check_flag("w.last", 1'b1, w.last);
            w_ready <= 1'b0;
            w_seen  <= 1'b1;
            wr_data <= w.data;
            wr_strb <= w.strb;
            w_wait  <= pick_delay();
         end else if (w_valid && !w_seen) begin
            if (w_wait == 0) w_ready <= 1'b1;
            else w_wait <= w_wait - 1;
         end
         if (b_valid && b_ready) begin
            b_valid <= 1'b0;
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
         end else if (aw_seen && w_seen && !b_valid) begin
            if (b_wait == 0) begin
               b_valid <= 1'b1;
               b.id    <= '0;
               b.resp  <= wr_addr[ERR_ADDR_BIT] ? ahb_axi_pkg::RESP_SLVERR
                                                : ahb_axi_pkg::RESP_OKAY;
               if (!wr_addr[ERR_ADDR_BIT]) begin
                  for (int k = 0; k < `AHB_STRB_W; k++)
                     if (wr_strb[k]) mem[wr_addr[11:2]][8*k +: 8] <= wr_data[8*k +: 8];
               end
               b_wait <= pick_delay();
            end else begin
               b_wait <= b_wait - 1;
            end
         end
      end
   end

   // ******************************
   // AXI slave memory, read side
   // ******************************
   always @(posedge clk) begin : read_slave
      if (rst_l) begin
         ar_ready <= 1'b0;
         r_valid  <= 1'b0;
         ar_seen  <= 1'b0;
         ar_wait  <= pick_delay();
         r_wait   <= pick_delay();
      end else begin
         if (ar_valid && ar_ready) begin
            if (!axi_expected)
               report_failure($sformatf("%s: AR transfer for a misaligned case", cur_name));
            check_ax("ar", exp_ax, ar);
            ar_ready <= 1'b0;
            ar_seen  <= 1'b1;
            rd_addr  <= ar.addr;
            ar_count <= ar_count + 1;
            ar_wait  <= pick_delay();
         end else if (ar_valid && !ar_seen) begin
            if (ar_wait == 0) ar_ready <= 1'b1;
            else ar_wait <= ar_wait - 1;
         end
         if (r_valid && r_ready) begin
            r_valid <= 1'b0;
            ar_seen <= 1'b0;
         end else if (ar_seen && !r_valid) begin
            if (r_wait == 0) begin
               r_valid <= 1'b1;
               r.id    <= '0;
               r.data  <= mem[rd_addr[11:2]];
               r.resp  <= rd_addr[ERR_ADDR_BIT] ? ahb_axi_pkg::RESP_SLVERR
                                                : ahb_axi_pkg::RESP_OKAY;
               r.last  <= 1'b1;
               r_wait  <= pick_delay();
            end else begin
               r_wait <= r_wait - 1;
            end
         end
      end
   end

   // ******************************
   // case player
   // ******************************
   task automatic load_cases();
      integer                 fd;
      string                  line;
      string                  name;
      string                  op;
      int                     size;
      int                     err;
      int                     cnt;
      logic [`AHB_ADDR_W-1:0] addr;
      logic [`AHB_DATA_W-1:0] wdata;
      logic [`AHB_DATA_W-1:0] rdata;
      case_t                  c;
      fd = $fopen("ahb_axi_cases.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open the case file ahb_axi_cases.txt");
      end else begin
         while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) break;
            if (line.len() < 2 || line[0] == "#") continue;   // comments, blank lines
            cnt = $sscanf(line, "%s %s %d %h %h %h %d", name, op, size, addr, wdata, rdata, err);
            if (cnt != 7 || (op != "wr" && op != "rd")) begin
               report_failure($sformatf("bad line in the case file: %s", line));
            end else begin
               c.write = (op == "wr");
               c.size  = size[2:0];
               c.addr  = addr;
               c.wdata = wdata;
               c.rdata = rdata;
               c.err   = err[0];
               cases.push_back(c);
               names.push_back(name);
            end
         end
         $fclose(fd);
         n_cases = cases.size();
      end
   endtask

   task automatic check_reset_state();
      check_flag("hreadyout", 1'b1, hreadyout);
      check_resp(1'b0, hresp);
      check_flag("aw_valid", 1'b0, aw_valid);
      check_flag("w_valid", 1'b0, w_valid);
      check_flag("ar_valid", 1'b0, ar_valid);
      check_flag("b_ready", 1'b0, b_ready);
      check_flag("r_ready", 1'b0, r_ready);
   endtask

   // one address phase, then the data phase until hreadyout comes back
   task automatic run_transfer(input case_t c, input logic [3:0] hprot, output logic resp,
                               output logic [`AHB_DATA_W-1:0] rdata);
      ahb_axi_pkg::ahb_in_t req;
      logic                 prev_resp;
      req.sel     = 1'b1;
      req.readyin = 1'b1;
      req.trans   = ahb_axi_pkg::TRANS_NONSEQ;
      req.write   = c.write;
      req.size    = ahb_axi_pkg::hsize_e'(c.size);
      req.prot    = hprot;
      req.addr    = c.addr;
      @(posedge clk);
      ahb_in <= req;
      @(negedge clk);
      while (!hreadyout) @(negedge clk);
      @(posedge clk);                     // address phase taken here
      ahb_in <= '0;
      hwdata <= c.wdata;
      @(negedge clk);
      if (hreadyout)
         report_failure($sformatf("%s: hreadyout stayed high after the address phase",
                                  cur_name));
      prev_resp = 1'b0;
      while (!hreadyout) begin
         prev_resp = hresp;
         @(negedge clk);
      end
      resp  = hresp;
      rdata = hrdata;
      if (hresp != prev_resp)
         report_failure($sformatf("%s: ERROR response was not two cycles long", cur_name));
   endtask

   initial begin : player
      case_t                  c;
      logic [31:0]            rnd;
      logic [3:0]             hprot;
      logic                   resp;
      logic [`AHB_DATA_W-1:0] rdata;
      int                     count_before;
      load_cases();
      cases_loaded = 1'b1;
      repeat (3) @(posedge clk);
      rst_l <= 1'b0;
      @(negedge clk);
      check_reset_state();
      for (int i = 0; i < n_cases; i++) begin
         c            = cases[i];
         cur_name     = names[i];
         rnd          = $random(seed);
         hprot        = rnd[3:0];
         exp_ax       = expect_ax(c, hprot);
         axi_expected = ~is_misaligned(c);
         count_before = aw_count + ar_count;
         run_transfer(c, hprot, resp, rdata);
         check_resp(c.err, resp);
         if (!c.err && !c.write) check_rdata(c.rdata, rdata);
         if (axi_expected && (aw_count + ar_count) == count_before)
            report_failure($sformatf("%s: no AW or AR transfer took place", cur_name));
      end
      repeat (2) @(posedge clk);
      if (n_cases == 0) begin
         report_failure("the case file holds no cases");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

   // run length follows the number of cases
   initial begin : watchdog
      wait (cases_loaded);
      #((n_cases * CYCLES_PER_CASE + 10) * CLK_PERIOD);
      report_failure($sformatf("timeout after %0d cycles, the cases did not finish",
                               n_cases * CYCLES_PER_CASE + 10));
   end

endmodule

// ==== files.f ====
+incdir+.
ahb_axi_pkg.sv
ahb_cmd_capture.sv
ahb_bridge_fsm.sv
axi_channel_drive.sv
ahb_to_axi4_top.sv
ahb_axi_asserts.sv
tb_ahb_to_axi4.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_ahb_to_axi4
FILELIST  := files.f
OBJ_DIR   := obj_dir
LINTFLAGS := --lint-only --timing --assert
SIMFLAGS  := --binary --timing --assert -j 0

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

# the binary exits non-zero when the testbench stops with $$fatal
sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== ahb_axi_cases.txt ====
# name op size addr wdata rdata err  (op wr or rd, size 0 byte 1 half 2 word, values in hex)
# rdata is checked on reads without error, err is the expected hresp at the end
rd_fill_040   rd 0 00000040 00000000 a5a50040 0
wr_word_100   wr 2 00000100 12345678 00000000 0
rd_word_100   rd 2 00000100 00000000 12345678 0
wr_word_200   wr 2 00000200 cafef00d 00000000 0
wr_byte_201   wr 0 00000201 0000aa00 00000000 0
wr_byte_203   wr 0 00000203 bb000000 00000000 0
rd_word_200   rd 2 00000200 00000000 bbfeaa0d 0
wr_half_202   wr 1 00000202 99880000 00000000 0
rd_word_200b  rd 2 00000200 00000000 9988aa0d 0
wr_byte_300   wr 0 00000300 000000ee 00000000 0
rd_byte_301   rd 0 00000301 00000000 a5a503ee 0
wr_half_odd   wr 1 00000101 0000ffff 00000000 1
wr_word_mis   wr 2 00000102 ffffffff 00000000 1
rd_word_mis   rd 2 00000203 00000000 00000000 1
rd_half_mis   rd 1 00000303 00000000 00000000 1
rd_after_mis  rd 2 00000100 00000000 12345678 0
wr_slverr     wr 2 80000010 deadbeef 00000000 1
rd_slverr     rd 2 80000010 00000000 00000000 1
rd_after_err  rd 2 00000010 00000000 a5a50010 0
wr_word_ffc   wr 2 00000ffc 0badc0de 00000000 0
wr_half_ffe   wr 1 00000ffe 55660000 00000000 0
rd_word_ffc   rd 2 00000ffc 00000000 5566c0de 0
